//--- host_pkg.sv
/* Boot host shared definitions */
package host_pkg;

  // Bus widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  // NBF record opcode
  typedef logic [7:0] nbf_op_t;

  // One bit per trace consumer
  typedef logic [7:0] trace_t;

  localparam nbf_op_t NBF_OP_WRITE  = 8'h03;
  localparam nbf_op_t NBF_OP_FINISH = 8'hff;

  // Host register map
  localparam addr_t HOST_PUTCHAR_ADDR = 32'h0000_0000;
  localparam addr_t HOST_FINISH_ADDR  = 32'h0000_0004;
  localparam addr_t HOST_TRACE_ADDR   = 32'h0000_0008;
  localparam addr_t HOST_STATUS_ADDR  = 32'h0000_000c;

  // Loader FSM
  typedef enum logic [1:0]
  {
    LOAD_IDLE = 2'd0,
    LOAD_BUSY = 2'd1,
    LOAD_DONE = 2'd2
  } nbf_state_e;

endpackage

//--- nbf_loader.sv
/* NBF boot record loader */
`timescale 1ns/1ps

module nbf_loader
  (
    input  logic            clk_i,
    input  logic            rst_n_i,

    input  logic            rec_v_i,
    input  host_pkg::nbf_op_t rec_op_i,
    input  host_pkg::addr_t rec_addr_i,
    input  host_pkg::data_t rec_data_i,
    output logic            rec_ready_o,

    output logic            cmd_v_o,
    output host_pkg::addr_t cmd_addr_o,
    output host_pkg::data_t cmd_data_o,
    input  logic            cmd_done_i,

    output logic            done_o
  );

  import host_pkg::*;

  nbf_state_e state_q;
  nbf_state_e state_d;
  addr_t      addr_q;
  data_t      data_q;
  logic       rec_fire;
  logic       is_write;

  assign rec_fire = rec_v_i & rec_ready_o;
  assign is_write = (rec_op_i == NBF_OP_WRITE);

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      LOAD_IDLE:
      begin
        // Unknown opcodes are consumed and dropped
        if (rec_fire && is_write)
          state_d = LOAD_BUSY;
        else if (rec_fire && rec_op_i == NBF_OP_FINISH)
          state_d = LOAD_DONE;
      end
      LOAD_BUSY:
      begin
        if (cmd_done_i)
          state_d = LOAD_IDLE;
      end
      LOAD_DONE:
        state_d = LOAD_DONE;
      default:
        state_d = LOAD_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      state_q <= LOAD_IDLE;
    else
      state_q <= state_d;
  end

  // Write payload captured on acceptance
  always_ff @(posedge clk_i)
  begin
    if (rec_fire && is_write)
    begin
      addr_q <= rec_addr_i;
      data_q <= rec_data_i;
    end
  end

  assign rec_ready_o = (state_q == LOAD_IDLE);
  assign cmd_v_o     = (state_q == LOAD_BUSY);
  assign cmd_addr_o  = addr_q;
  assign cmd_data_o  = data_q;
  assign done_o      = (state_q == LOAD_DONE);

endmodule

//--- mem_write_master.sv
/* Wishbone write master */
`timescale 1ns/1ps

module mem_write_master
  (
    input  logic            clk_i,
    input  logic            rst_n_i,

    input  logic            cmd_v_i,
    input  host_pkg::addr_t cmd_addr_i,
    input  host_pkg::data_t cmd_data_i,
    output logic            cmd_done_o,

    output logic            mem_cyc_o,
    output logic            mem_stb_o,
    output logic            mem_we_o,
    output host_pkg::addr_t mem_adr_o,
    output host_pkg::data_t mem_dat_o,
    output logic [$bits(host_pkg::data_t)/8-1:0] mem_sel_o,
    input  logic            mem_ack_i
  );

  import host_pkg::*;

  logic  cyc_q;
  logic  start;
  logic  finish;
  addr_t adr_q;
  data_t dat_q;

  // New command only when no cycle is open
  assign start  = cmd_v_i & ~cyc_q;
  assign finish = cyc_q & mem_ack_i;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      cyc_q <= 1'b0;
    else if (start)
      cyc_q <= 1'b1;
    else if (finish)
      cyc_q <= 1'b0;
  end

  // Held steady until the ack edge
  always_ff @(posedge clk_i)
  begin
    if (start)
    begin
      adr_q <= cmd_addr_i;
      dat_q <= cmd_data_i;
    end
  end

  assign mem_cyc_o  = cyc_q;
  assign mem_stb_o  = cyc_q;
  assign mem_we_o   = cyc_q;
  assign mem_adr_o  = adr_q;
  assign mem_dat_o  = dat_q;
  assign mem_sel_o  = '1;
  assign cmd_done_o = finish;

endmodule

//--- host_io_regs.sv
/* Host I/O register block */
`timescale 1ns/1ps

module host_io_regs
  #(
    parameter int num_harts_p = 4
  )
  (
    input  logic                   clk_i,
    input  logic                   rst_n_i,

    input  logic                   io_cyc_i,
    input  logic                   io_stb_i,
    input  logic                   io_we_i,
    input  host_pkg::addr_t        io_adr_i,
    input  host_pkg::data_t        io_dat_i,
    output host_pkg::data_t        io_dat_o,
    output logic                   io_ack_o,

    input  logic                   loader_done_i,

    output logic [7:0]             char_o,
    output logic                   char_v_o,
    output host_pkg::trace_t       trace_en_o,
    output logic [num_harts_p-1:0] finish_o,
    output logic                   all_finished_o
  );

  import host_pkg::*;

  logic                   ack_q;
  logic                   req;
  logic                   wr;
  logic                   char_v_q;
  logic [7:0]             char_q;
  trace_t                 trace_q;
  logic [num_harts_p-1:0] finish_q;
  logic [num_harts_p-1:0] finish_set;
  logic [3:0]             hart_idx;
  data_t                  rd_mux;
  data_t                  rd_q;

  // New request when strobe is seen with no ack out
  assign req = io_cyc_i & io_stb_i & ~ack_q;
  assign wr  = req & io_we_i;

  // Hart index wraps on the hart count
  assign hart_idx = 4'(io_dat_i[3:0] % num_harts_p);

  always_comb
  begin
    finish_set = '0;
    for (int i = 0; i < num_harts_p; i++)
    begin
      if (hart_idx == i)
        finish_set[i] = 1'b1;
    end
  end

  always_comb
  begin
    case (io_adr_i)
      HOST_FINISH_ADDR: rd_mux = data_t'(finish_q);
      HOST_TRACE_ADDR:  rd_mux = data_t'(trace_q);
      HOST_STATUS_ADDR: rd_mux = data_t'(loader_done_i);
      default:          rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      ack_q    <= 1'b0;
      char_v_q <= 1'b0;
      trace_q  <= '0;
      finish_q <= '0;
    end
    else
    begin
      ack_q    <= req;
      char_v_q <= wr && (io_adr_i == HOST_PUTCHAR_ADDR);
      if (wr && io_adr_i == HOST_TRACE_ADDR)
        trace_q <= io_dat_i[7:0];
      if (wr && io_adr_i == HOST_FINISH_ADDR)
        finish_q <= finish_q | finish_set;
    end
  end

  // Character and read data
  always_ff @(posedge clk_i)
  begin
    if (wr && io_adr_i == HOST_PUTCHAR_ADDR)
      char_q <= io_dat_i[7:0];
    if (req)
      rd_q <= io_we_i ? '0 : rd_mux;
  end

  assign io_ack_o       = ack_q;
  assign io_dat_o       = rd_q;
  assign char_o         = char_q;
  assign char_v_o       = char_v_q;
  assign trace_en_o     = trace_q;
  assign finish_o       = finish_q;
  assign all_finished_o = &finish_q;

endmodule

//--- boot_host_top.sv
/* Boot and host controller */
`timescale 1ns/1ps

module boot_host_top
  #(
    parameter int num_harts_p = 4
  )
  (
    input  logic                   clk_i,
    input  logic                   rst_n_i,

    input  logic                   rec_v_i,
    input  host_pkg::nbf_op_t      rec_op_i,
    input  host_pkg::addr_t        rec_addr_i,
    input  host_pkg::data_t        rec_data_i,
    output logic                   rec_ready_o,

    output logic                   mem_cyc_o,
    output logic                   mem_stb_o,
    output logic                   mem_we_o,
    output host_pkg::addr_t        mem_adr_o,
    output host_pkg::data_t        mem_dat_o,
    output logic [$bits(host_pkg::data_t)/8-1:0] mem_sel_o,
    input  logic                   mem_ack_i,

    input  logic                   io_cyc_i,
    input  logic                   io_stb_i,
    input  logic                   io_we_i,
    input  host_pkg::addr_t        io_adr_i,
    input  host_pkg::data_t        io_dat_i,
    output host_pkg::data_t        io_dat_o,
    output logic                   io_ack_o,

    output logic [7:0]             char_o,
    output logic                   char_v_o,
    output host_pkg::trace_t       trace_en_o,
    output logic [num_harts_p-1:0] finish_o,
    output logic                   all_finished_o,
    output logic                   loader_done_o
  );

  import host_pkg::*;

  logic  cmd_v;
  addr_t cmd_addr;
  data_t cmd_data;
  logic  cmd_done;
  logic  load_done;

  nbf_loader loader_i
    (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .rec_v_i     (rec_v_i),
      .rec_op_i    (rec_op_i),
      .rec_addr_i  (rec_addr_i),
      .rec_data_i  (rec_data_i),
      .rec_ready_o (rec_ready_o),
      .cmd_v_o     (cmd_v),
      .cmd_addr_o  (cmd_addr),
      .cmd_data_o  (cmd_data),
      .cmd_done_i  (cmd_done),
      .done_o      (load_done)
    );

  mem_write_master mem_master_i
    (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .cmd_v_i    (cmd_v),
      .cmd_addr_i (cmd_addr),
      .cmd_data_i (cmd_data),
      .cmd_done_o (cmd_done),
      .mem_cyc_o  (mem_cyc_o),
      .mem_stb_o  (mem_stb_o),
      .mem_we_o   (mem_we_o),
      .mem_adr_o  (mem_adr_o),
      .mem_dat_o  (mem_dat_o),
      .mem_sel_o  (mem_sel_o),
      .mem_ack_i  (mem_ack_i)
    );

  host_io_regs
    #(
      .num_harts_p (num_harts_p)
    )
  host_i
    (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .io_cyc_i       (io_cyc_i),
      .io_stb_i       (io_stb_i),
      .io_we_i        (io_we_i),
      .io_adr_i       (io_adr_i),
      .io_dat_i       (io_dat_i),
      .io_dat_o       (io_dat_o),
      .io_ack_o       (io_ack_o),
      .loader_done_i  (load_done),
      .char_o         (char_o),
      .char_v_o       (char_v_o),
      .trace_en_o     (trace_en_o),
      .finish_o       (finish_o),
      .all_finished_o (all_finished_o)
    );

  assign loader_done_o = load_done;

endmodule

//--- boot_host_assert.sv
/* Boot host protocol checks */
`timescale 1ns/1ps

module boot_host_assert
  (
    input logic            clk_i,
    input logic            rst_n_i,
    input logic            mem_cyc_i,
    input logic            mem_stb_i,
    input logic            mem_ack_i,
    input host_pkg::addr_t mem_adr_i,
    input host_pkg::data_t mem_dat_i,
    input logic            io_ack_i,
    input logic            rec_ready_i,
    input logic            loader_done_i
  );

  stb_in_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_stb_i |-> mem_cyc_i)
    else $error("mem_stb_o high outside a bus cycle");

  // Address and data frozen until ack
  mem_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mem_stb_i && !mem_ack_i) |=> ($stable(mem_adr_i) && $stable(mem_dat_i)))
    else $error("memory address or data changed before ack");

  io_ack_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    io_ack_i |=> !io_ack_i)
    else $error("io_ack_o held longer than one cycle");

  ready_after_done: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    loader_done_i |-> (!rec_ready_i ##1 (loader_done_i && !rec_ready_i)))
    else $error("rec_ready_o high after the load finished");

endmodule

bind boot_host_top boot_host_assert assert_i
  (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .mem_cyc_i     (mem_cyc_o),
    .mem_stb_i     (mem_stb_o),
    .mem_ack_i     (mem_ack_i),
    .mem_adr_i     (mem_adr_o),
    .mem_dat_i     (mem_dat_o),
    .io_ack_i      (io_ack_o),
    .rec_ready_i   (rec_ready_o),
    .loader_done_i (loader_done_o)
  );

//--- boot_host_tb.sv
/* Boot host testbench */
`timescale 1ns/1ps

module boot_host_tb;

  import host_pkg::*;

  localparam int num_harts = 4;

  logic                 clk_i;
  logic                 rst_n_i;
  logic                 rec_v_i;
  nbf_op_t              rec_op_i;
  addr_t                rec_addr_i;
  data_t                rec_data_i;
  logic                 rec_ready_o;
  logic                 mem_cyc_o;
  logic                 mem_stb_o;
  logic                 mem_we_o;
  addr_t                mem_adr_o;
  data_t                mem_dat_o;
  logic [3:0]           mem_sel_o;
  logic                 mem_ack_i;
  logic                 io_cyc_i;
  logic                 io_stb_i;
  logic                 io_we_i;
  addr_t                io_adr_i;
  data_t                io_dat_i;
  data_t                io_dat_o;
  logic                 io_ack_o;
  logic [7:0]           char_o;
  logic                 char_v_o;
  trace_t               trace_en_o;
  logic [num_harts-1:0] finish_o;
  logic                 all_finished_o;
  logic                 loader_done_o;

  // Record table and I/O table
  nbf_op_t rec_op_q[$];
  addr_t   rec_addr_q[$];
  data_t   rec_data_q[$];
  logic    io_we_q[$];
  addr_t   io_adr_q[$];
  data_t   io_wdat_q[$];
  data_t   io_exp_q[$];

  // Memory writes still owed by the loader in order
  addr_t exp_addr_q[$];
  data_t exp_data_q[$];

  trace_t               exp_trace;
  logic [num_harts-1:0] exp_finish;
  integer               seed = 32'hdc50_77f8;
  int                   cycle_cnt = 0;
  int                   timeout_limit = 1000;

  boot_host_top #(.num_harts_p(num_harts)) dut_i (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic abort_run();
    $display("Done: errors found");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp)
    begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp)
    begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_trace(input string name, input trace_t got, input trace_t exp);
    if (got !== exp)
    begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_char(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
    begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic add_rec(input nbf_op_t op, input addr_t addr, input data_t data,
                         input logic exp_wr);
    rec_op_q.push_back(op);
    rec_addr_q.push_back(addr);
    rec_data_q.push_back(data);
    if (exp_wr)
    begin
      exp_addr_q.push_back(addr);
      exp_data_q.push_back(data);
    end
  endtask

  task automatic add_io(input logic we, input addr_t adr, input data_t wdat, input data_t exp);
    io_we_q.push_back(we);
    io_adr_q.push_back(adr);
    io_wdat_q.push_back(wdat);
    io_exp_q.push_back(exp);
  endtask

  task automatic build_tables();
    // op, address, data, expect a memory write
    add_rec(NBF_OP_WRITE,  32'h8000_0000, 32'h0000_0013, 1'b1);
    add_rec(NBF_OP_WRITE,  32'h8000_0004, 32'hdead_beef, 1'b1);
    add_rec(8'h05,         32'h8000_0008, 32'h1111_1111, 1'b0);
    add_rec(NBF_OP_WRITE,  32'h8000_0008, 32'h1234_5678, 1'b1);
    add_rec(8'h00,         32'h0000_0000, 32'h0000_0000, 1'b0);
    add_rec(NBF_OP_WRITE,  32'h8000_1000, 32'ha5a5_5a5a, 1'b1);
    add_rec(NBF_OP_WRITE,  32'h8000_1ffc, 32'h0bad_f00d, 1'b1);
    add_rec(NBF_OP_FINISH, 32'h0000_0000, 32'h0000_0000, 1'b0);
    // write, offset, write data, expected read data
    add_io(1'b1, HOST_PUTCHAR_ADDR, 32'h0000_0048, 32'h0);
    add_io(1'b1, HOST_PUTCHAR_ADDR, 32'h1234_5669, 32'h0);
    add_io(1'b0, HOST_TRACE_ADDR,   32'h0,         32'h0);
    add_io(1'b1, HOST_TRACE_ADDR,   32'h0000_03a5, 32'h0);
    add_io(1'b0, HOST_TRACE_ADDR,   32'h0,         32'h0000_00a5);
    add_io(1'b0, HOST_FINISH_ADDR,  32'h0,         32'h0);
    add_io(1'b1, HOST_FINISH_ADDR,  32'h0000_0001, 32'h0);
    add_io(1'b0, HOST_FINISH_ADDR,  32'h0,         32'h0000_0002);
    add_io(1'b1, HOST_FINISH_ADDR,  32'h0000_0006, 32'h0);
    add_io(1'b1, HOST_FINISH_ADDR,  32'h0000_0000, 32'h0);
    add_io(1'b0, HOST_FINISH_ADDR,  32'h0,         32'h0000_0007);
    add_io(1'b1, 32'h0000_0010,     32'h0000_00ff, 32'h0);
    add_io(1'b0, 32'h0000_0010,     32'h0,         32'h0);
    add_io(1'b1, HOST_STATUS_ADDR,  32'h0000_0000, 32'h0);
    add_io(1'b0, HOST_STATUS_ADDR,  32'h0,         32'h0000_0001);
    add_io(1'b1, HOST_FINISH_ADDR,  32'h0000_000f, 32'h0);
    add_io(1'b0, HOST_FINISH_ADDR,  32'h0,         32'h0000_000f);
    add_io(1'b0, HOST_TRACE_ADDR,   32'h0,         32'h0000_00a5);
    add_io(1'b0, HOST_PUTCHAR_ADDR, 32'h0,         32'h0);
    add_io(1'b0, 32'h0000_0020,     32'h0,         32'h0);
  endtask

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic send_record(input nbf_op_t op, input addr_t addr, input data_t data);
    rec_v_i    = 1'b1;
    rec_op_i   = op;
    rec_addr_i = addr;
    rec_data_i = data;
    while (!rec_ready_o)
      @(negedge clk_i);
    @(negedge clk_i);
    rec_v_i = 1'b0;
  endtask

  task automatic io_access(input logic we, input addr_t adr, input data_t wdat,
                           input data_t exp_rd);
    logic is_char;
    is_char = we && (adr == HOST_PUTCHAR_ADDR);
    check_bit("io_ack_o", io_ack_o, 1'b0);
    io_cyc_i = 1'b1;
    io_stb_i = 1'b1;
    io_we_i  = we;
    io_adr_i = adr;
    io_dat_i = wdat;
    if (we && adr == HOST_TRACE_ADDR)
      exp_trace = wdat[7:0];
    if (we && adr == HOST_FINISH_ADDR)
      exp_finish[wdat % num_harts] = 1'b1;
    @(negedge clk_i);
    // Ack one cycle after the request
    check_bit("io_ack_o", io_ack_o, 1'b1);
    check_bit("char_v_o", char_v_o, is_char);
    if (is_char)
      check_char("char_o", char_o, wdat[7:0]);
    if (!we)
      check_data("io_dat_o", io_dat_o, exp_rd);
    check_trace("trace_en_o", trace_en_o, exp_trace);
    check_data("finish_o", data_t'(finish_o), data_t'(exp_finish));
    check_bit("all_finished_o", all_finished_o, &exp_finish);
    // Request stays up through the ack edge as a Wishbone master does
    @(negedge clk_i);
    check_bit("io_ack_o", io_ack_o, 1'b0);
    check_bit("char_v_o", char_v_o, 1'b0);
    io_cyc_i = 1'b0;
    io_stb_i = 1'b0;
    io_we_i  = 1'b0;
  endtask

  task automatic log_write();
    $display("mem write %h <= %h", mem_adr_o, mem_dat_o);
    check_bit("mem_we_o", mem_we_o, 1'b1);
    check_bit("mem_sel_o", &mem_sel_o, 1'b1);
    if (exp_addr_q.size() == 0)
    begin
      $display("Memory write seen with no write record left to match it");
      abort_run();
    end
    else
    begin
      check_addr("mem_adr_o", mem_adr_o, exp_addr_q.pop_front());
      check_data("mem_dat_o", mem_dat_o, exp_data_q.pop_front());
    end
  endtask

  // Memory model that acks after 0 to 3 cycles
  initial
  begin : mem_responder
    int unsigned delay;
    logic        busy;
    mem_ack_i = 1'b0;
    delay     = 0;
    busy      = 1'b0;
    forever
    begin
      @(negedge clk_i);
      mem_ack_i = 1'b0;
      if (mem_cyc_o && mem_stb_o)
      begin
        if (!busy)
        begin
          busy  = 1'b1;
          delay = $unsigned($random(seed)) % 4;
          log_write();
        end
        if (delay == 0)
        begin
          mem_ack_i = 1'b1;
          busy      = 1'b0;
        end
        else
          delay--;
      end
    end
  end

  always @(posedge clk_i)
  begin
    cycle_cnt++;
    if (cycle_cnt > timeout_limit)
    begin
      $display("Timeout: run did not end within %0d cycles", timeout_limit);
      abort_run();
    end
  end

  initial
  begin : main
    rst_n_i    = 1'b0;
    rec_v_i    = 1'b0;
    rec_op_i   = '0;
    rec_addr_i = '0;
    rec_data_i = '0;
    io_cyc_i   = 1'b0;
    io_stb_i   = 1'b0;
    io_we_i    = 1'b0;
    io_adr_i   = '0;
    io_dat_i   = '0;
    exp_trace  = '0;
    exp_finish = '0;
    build_tables();
    timeout_limit = 16 + 6 * rec_op_q.size() + 3 * (io_we_q.size() + 1) + 100;

    repeat (16) @(negedge clk_i);
    check_bit("mem_cyc_o", mem_cyc_o, 1'b0);
    check_bit("mem_stb_o", mem_stb_o, 1'b0);
    check_bit("io_ack_o", io_ack_o, 1'b0);
    check_bit("char_v_o", char_v_o, 1'b0);
    check_bit("loader_done_o", loader_done_o, 1'b0);
    check_bit("all_finished_o", all_finished_o, 1'b0);
    check_trace("trace_en_o", trace_en_o, '0);
    check_bit("rec_ready_o", rec_ready_o, 1'b1);
    rst_n_i = 1'b1;
    @(negedge clk_i);

    // Status reads zero before the load
    io_access(1'b0, HOST_STATUS_ADDR, '0, 32'h0);

    for (int i = 0; i < rec_op_q.size(); i++)
      send_record(rec_op_q[i], rec_addr_q[i], rec_data_q[i]);
    check_bit("loader_done_o", loader_done_o, 1'b1);
    check_bit("rec_ready_o", rec_ready_o, 1'b0);
    if (exp_addr_q.size() != 0)
    begin
      $display("Loader finished with %0d memory writes missing", exp_addr_q.size());
      abort_run();
    end

    for (int i = 0; i < io_we_q.size(); i++)
      io_access(io_we_q[i], io_adr_q[i], io_wdat_q[i], io_exp_q[i]);
    check_bit("rec_ready_o", rec_ready_o, 1'b0);
    check_bit("loader_done_o", loader_done_o, 1'b1);

    $display("Done: no errors");
    $finish;
  end

endmodule

//--- filelist.f
host_pkg.sv
nbf_loader.sv
mem_write_master.sv
host_io_regs.sv
boot_host_top.sv
boot_host_assert.sv
boot_host_tb.sv

//--- Makefile
TOP = boot_host_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): filelist.f $(wildcard *.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f filelist.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	grep -q "Done: no errors" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module boot_host_top \
		host_pkg.sv nbf_loader.sv mem_write_master.sv host_io_regs.sv boot_host_top.sv

clean:
	rm -rf obj_dir sim.log
